// File: data_select_stage.sv
`default_nettype none

module data_select_stage (
    input  rv_pkg::id_t  id,
    input  logic [31:0]  regfile [32],
    input  rv_pkg::fw_t  exe_fw,
    input  rv_pkg::fw_t  mem_fw,
    input  rv_pkg::fw_t  wb_fw,
    output logic         stall,
    output rv_pkg::exe_t ds_exe
);
    import rv_pkg::*;

    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] op1_data;
    logic [31:0] op2_data;

    function automatic logic fw_hit(input fw_t fw, input logic [4:0] addr);
        return fw.valid && (fw.addr == addr) && (addr != 5'd0);
    endfunction

    // rs fields are compared even when the format does not use them
    assign rs1_addr = id.inst[19:15];
    assign rs2_addr = id.inst[24:20];

    // exe slot result is not ready yet, so wait one cycle
    assign stall = id.valid && (fw_hit(exe_fw, rs1_addr) || fw_hit(exe_fw, rs2_addr));

    // mem has priority over wb, the younger write wins
    assign rs1_data = (rs1_addr == 5'd0)       ? 32'd0 :
                      fw_hit(mem_fw, rs1_addr) ? mem_fw.wdata :
                      fw_hit(wb_fw, rs1_addr)  ? wb_fw.wdata :
                                                 regfile[rs1_addr];

    assign rs2_data = (rs2_addr == 5'd0)       ? 32'd0 :
                      fw_hit(mem_fw, rs2_addr) ? mem_fw.wdata :
                      fw_hit(wb_fw, rs2_addr)  ? wb_fw.wdata :
                                                 regfile[rs2_addr];

    always_comb begin
        case (id.ctrl.op1_sel)
            OP1_RS1: op1_data = rs1_data;
            OP1_PC:  op1_data = id.pc;
            default: op1_data = 32'd0;
        endcase
    end

    always_comb begin
        case (id.ctrl.op2_sel)
            OP2_RS2: op2_data = rs2_data;
            OP2_IMI: op2_data = id.imm_i;
            OP2_IMU: op2_data = id.imm_u;
            default: op2_data = 32'd0;
        endcase
    end

    // a stall turns the exe slot input into a bubble
    always_comb begin
        ds_exe.valid    = id.valid && !stall;
        ds_exe.pc       = id.pc;
        ds_exe.rf_wen   = id.ctrl.rf_wen;
        ds_exe.wb_addr  = id.ctrl.wb_addr;
        ds_exe.alu_fn   = id.ctrl.alu_fn;
        ds_exe.op1_data = op1_data;
        ds_exe.op2_data = op2_data;
    end

endmodule

`default_nettype wire

// File: decode_stage.sv
`default_nettype none

module decode_stage (
    input  logic        clk,
    input  logic        rst,
    input  logic        inst_valid,
    input  logic [31:0] inst,
    input  logic [31:0] pc,
    input  logic        stall,
    output rv_pkg::id_t id
);
    import rv_pkg::*;

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    logic        valid_q;
    logic [31:0] pc_q;
    logic [31:0] inst_q;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    ctrl_t       ctrl;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= inst_valid;
        end
    end

    // payload loads only on an accepted instruction
    always_ff @(posedge clk) begin
        if (inst_valid && !stall) begin
            pc_q   <= pc;
            inst_q <= inst;
        end
    end

    assign opcode = inst_q[6:0];
    assign funct3 = inst_q[14:12];
    assign funct7 = inst_q[31:25];

    always_comb begin
        ctrl.alu_fn  = ALU_ADD;
        ctrl.op1_sel = OP1_RS1;
        ctrl.op2_sel = OP2_RS2;
        ctrl.rf_wen  = 1'b0;
        ctrl.wb_addr = inst_q[11:7];
        case (opcode)
            OPC_OP_IMM: begin
                ctrl.op2_sel = OP2_IMI;
                ctrl.rf_wen  = 1'b1;
                case (funct3)
                    3'b000: ctrl.alu_fn = ALU_ADD;
                    3'b010: ctrl.alu_fn = ALU_SLT;
                    3'b100: ctrl.alu_fn = ALU_XOR;
                    3'b110: ctrl.alu_fn = ALU_OR;
                    3'b111: ctrl.alu_fn = ALU_AND;
                    3'b001: ctrl.alu_fn = ALU_SLL;
                    3'b101: ctrl.alu_fn = ALU_SRL;
                    default: ctrl.rf_wen = 1'b0;
                endcase
                // shift immediates need funct7 zero, srai is not supported
                if ((funct3 == 3'b001 || funct3 == 3'b101) && funct7 != 7'b0000000) begin
                    ctrl.rf_wen = 1'b0;
                end
            end
            OPC_OP: begin
                ctrl.rf_wen = (funct7 == 7'b0000000);
                case (funct3)
                    3'b000: begin
                        if (funct7 == 7'b0100000) begin
                            ctrl.alu_fn = ALU_SUB;
                            ctrl.rf_wen = 1'b1;
                        end
                    end
                    3'b010: ctrl.alu_fn = ALU_SLT;
                    3'b100: ctrl.alu_fn = ALU_XOR;
                    3'b110: ctrl.alu_fn = ALU_OR;
                    3'b111: ctrl.alu_fn = ALU_AND;
                    3'b001: ctrl.alu_fn = ALU_SLL;
                    3'b101: ctrl.alu_fn = ALU_SRL;
                    default: ctrl.rf_wen = 1'b0;
                endcase
            end
            OPC_LUI: begin
                ctrl.op1_sel = OP1_ZERO;
                ctrl.op2_sel = OP2_IMU;
                ctrl.rf_wen  = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl.op1_sel = OP1_PC;
                ctrl.op2_sel = OP2_IMU;
                ctrl.rf_wen  = 1'b1;
            end
            // everything else retires as a no-op
            default: ctrl.rf_wen = 1'b0;
        endcase
    end

    always_comb begin
        id.valid = valid_q;
        id.pc    = pc_q;
        id.inst  = inst_q;
        id.ctrl  = ctrl;
        id.imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
        id.imm_u = {inst_q[31:12], 12'd0};
    end

endmodule

`default_nettype wire

// File: execute_stage.sv
`default_nettype none

module execute_stage (
    input  logic         clk,
    input  logic         rst,
    input  rv_pkg::exe_t ds_exe,
    output rv_pkg::res_t exe_res,
    output rv_pkg::fw_t  exe_fw
);
    import rv_pkg::*;

    exe_t        exe_q;
    logic [31:0] alu_out;
    logic [4:0]  shamt;

    // exe slot register
    always_ff @(posedge clk) begin
        if (rst) begin
            exe_q.valid <= 1'b0;
        end else begin
            exe_q <= ds_exe;
        end
    end

    assign shamt = exe_q.op2_data[4:0];

    always_comb begin
        case (exe_q.alu_fn)
            ALU_ADD: alu_out = exe_q.op1_data + exe_q.op2_data;
            ALU_SUB: alu_out = exe_q.op1_data - exe_q.op2_data;
            ALU_SLT: begin
                alu_out = {31'd0, $signed(exe_q.op1_data) < $signed(exe_q.op2_data)};
            end
            ALU_XOR: alu_out = exe_q.op1_data ^ exe_q.op2_data;
            ALU_OR:  alu_out = exe_q.op1_data | exe_q.op2_data;
            ALU_AND: alu_out = exe_q.op1_data & exe_q.op2_data;
            ALU_SLL: alu_out = exe_q.op1_data << shamt;
            ALU_SRL: alu_out = exe_q.op1_data >> shamt;
            default: alu_out = 32'd0;
        endcase
    end

    always_comb begin
        exe_res.valid   = exe_q.valid;
        exe_res.pc      = exe_q.pc;
        exe_res.rf_wen  = exe_q.rf_wen;
        exe_res.wb_addr = exe_q.wb_addr;
        exe_res.data    = alu_out;
    end

    // hazard report only, this slot never forwards
    always_comb begin
        exe_fw.valid = exe_q.valid && exe_q.rf_wen && (exe_q.wb_addr != 5'd0);
        exe_fw.addr  = exe_q.wb_addr;
        exe_fw.wdata = 32'd0;
    end

endmodule

`default_nettype wire

// File: flist.f
rv_pkg.sv
decode_stage.sv
data_select_stage.sv
execute_stage.sv
writeback_stage.sv
rv_core_pipe.sv
tb_rv_core_pipe.sv

// File: run.sh
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_rv_core_pipe \
    -f flist.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

// File: rv_core_pipe.sv
`default_nettype none

module rv_core_pipe (
    input  logic            clk,
    input  logic            rst,
    input  logic            inst_valid,
    input  logic [31:0]     inst,
    input  logic [31:0]     pc,
    output logic            stall,
    output logic            retire_valid,
    output rv_pkg::retire_t retire
);
    import rv_pkg::*;

    id_t         id;
    exe_t        ds_exe;
    res_t        exe_res;
    fw_t         exe_fw;
    fw_t         mem_fw;
    fw_t         wb_fw;
    logic [31:0] regfile [32];

    decode_stage decode_stage0 (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .pc         (pc),
        .stall      (stall),
        .id         (id)
    );

    data_select_stage data_select_stage0 (
        .id      (id),
        .regfile (regfile),
        .exe_fw  (exe_fw),
        .mem_fw  (mem_fw),
        .wb_fw   (wb_fw),
        .stall   (stall),
        .ds_exe  (ds_exe)
    );

    execute_stage execute_stage0 (
        .clk     (clk),
        .rst     (rst),
        .ds_exe  (ds_exe),
        .exe_res (exe_res),
        .exe_fw  (exe_fw)
    );

    // mem and wb slots plus the register file
    writeback_stage writeback_stage0 (
        .clk          (clk),
        .rst          (rst),
        .exe_res      (exe_res),
        .regfile      (regfile),
        .mem_fw       (mem_fw),
        .wb_fw        (wb_fw),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

`default_nettype wire

// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

    // operand 1 source
    typedef enum logic [1:0] {
        OP1_RS1,
        OP1_PC,
        OP1_ZERO
    } op1_sel_e;

    // operand 2 source
    typedef enum logic [1:0] {
        OP2_RS2,
        OP2_IMI,
        OP2_IMU
    } op2_sel_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL
    } alu_fn_e;

    // decoded control fields
    typedef struct packed {
        alu_fn_e     alu_fn;
        op1_sel_e    op1_sel;
        op2_sel_e    op2_sel;
        logic        rf_wen;
        logic [4:0]  wb_addr;
    } ctrl_t;

    // decode stage output
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
        ctrl_t       ctrl;
        logic [31:0] imm_i;
        logic [31:0] imm_u;
    } id_t;

    // operands selected for the exe slot
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        rf_wen;
        logic [4:0]  wb_addr;
        alu_fn_e     alu_fn;
        logic [31:0] op1_data;
        logic [31:0] op2_data;
    } exe_t;

    // result in flight through exe, mem and wb
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        rf_wen;
        logic [4:0]  wb_addr;
        logic [31:0] data;
    } res_t;

    // valid only when the slot writes a nonzero register
    typedef struct packed {
        logic        valid;
        logic [4:0]  addr;
        logic [31:0] wdata;
    } fw_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        wen;
        logic [31:0] data;
    } retire_t;

endpackage

`default_nettype wire

// File: tb_rv_core_pipe.sv
`default_nettype none

module tb_rv_core_pipe;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int N_INST     = 65;
    // kinds 0..7 are OP, 8..15 are OP-IMM, both indexed add sub slt xor or and sll srl
    localparam int K_LUI      = 16;
    localparam int K_AUIPC    = 17;
    localparam int K_NOP      = 18;
    localparam logic [2:0] F3 [8] = '{3'd0, 3'd0, 3'd2, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5};

    // what the timing model tracks per pipeline slot
    typedef struct packed {
        logic       v;
        logic       wen;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
    } slot_t;

    typedef struct packed {
        retire_t rec;
        logic    chk;
    } exp_t;

    logic        clk;
    logic        rst;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        stall;
    logic        retire_valid;
    retire_t     retire;

    logic [31:0] regs [32];
    exp_t        exp_q [$];
    exp_t        head;
    logic        head_ok;
    logic        take;
    slot_t       m_dec;
    slot_t       m_exe;
    logic        m_mem;
    logic        m_wb;
    logic        cur_wen;
    logic        exp_stall;
    logic [31:0] next_pc;
    int          errors;
    int          kind;

    rv_core_pipe dut0 (
        .clk          (clk),
        .rst          (rst),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .pc           (pc),
        .stall        (stall),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(CLK_PERIOD * (N_INST * 8 + 50));
        $display("watchdog expired before every instruction retired");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    function automatic logic [31:0] encode_inst(input int k, input logic [4:0] rd,
            input logic [4:0] rs1, input logic [4:0] rs2, input logic [31:0] imm);
        logic [2:0] f;
        f = 3'(k);
        if (k < 8) begin
            return {(f == 3'd1) ? 7'b0100000 : 7'd0, rs2, rs1, F3[f], rd, 7'b0110011};
        end
        if (k < K_LUI) begin
            if (f >= 3'd6) begin
                return {7'd0, imm[4:0], rs1, F3[f], rd, 7'b0010011};
            end
            return {imm[11:0], rs1, F3[f], rd, 7'b0010011};
        end
        if (k == K_LUI) begin
            return {imm[31:12], rd, 7'b0110111};
        end
        if (k == K_AUIPC) begin
            return {imm[31:12], rd, 7'b0010111};
        end
        // custom-0 opcode, outside the supported set
        return {imm[11:0], rs1, 3'b000, rd, 7'b0001011};
    endfunction

    function automatic logic [31:0] alu_ref(input int k, input logic [31:0] a,
            input logic [31:0] b);
        case (k % 8)
            0: return a + b;
            1: return a - b;
            2: return {31'd0, $signed(a) < $signed(b)};
            3: return a ^ b;
            4: return a | b;
            5: return a & b;
            6: return a << b[4:0];
            default: return a >> b[4:0];
        endcase
    endfunction

    task automatic refresh_head();
        head_ok = (exp_q.size() != 0);
        if (head_ok) begin
            head = exp_q[0];
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expv,
            input logic [31:0] got);
        errors++;
        $display("CHECK FAILED %s expected %h got %h", name, expv, got);
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    // reference result, then drive and hold until the DUT accepts
    task automatic issue(input int k, input logic [4:0] rd, input logic [4:0] rs1,
            input logic [4:0] rs2, input logic [31:0] imm);
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
        exp_t        e;
        word = encode_inst(k, rd, rs1, rs2, imm);
        a = regs[rs1];
        b = (k >= 8) ? {{20{word[31]}}, word[31:20]} : regs[rs2];
        if (k == K_LUI || k == K_AUIPC) begin
            a = (k == K_AUIPC) ? next_pc : 32'd0;
            b = {word[31:12], 12'd0};
        end
        e.rec.pc   = next_pc;
        e.rec.rd   = rd;
        e.rec.wen  = (k != K_NOP) && (rd != 5'd0);
        e.rec.data = (k >= K_LUI) ? a + b : alu_ref(k, a, b);
        e.chk      = (k != K_NOP);
        if (e.rec.wen) begin
            regs[rd] = e.rec.data;
        end
        exp_q.push_back(e);
        refresh_head();
        inst_valid = 1'b1;
        inst       = word;
        pc         = next_pc;
        cur_wen    = e.rec.wen;
        next_pc    = next_pc + 32'd4;
        while (stall) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #2;
        inst_valid = 1'b0;
    endtask

    // hazard when decode reads the destination held in exe
    assign exp_stall = m_dec.v && m_exe.v && m_exe.wen &&
                       ((m_dec.rs1 == m_exe.rd && m_dec.rs1 != 5'd0) ||
                        (m_dec.rs2 == m_exe.rd && m_dec.rs2 != 5'd0));

    always @(posedge clk) begin
        if (rst) begin
            m_dec <= '0;
            m_exe <= '0;
            m_mem <= 1'b0;
            m_wb  <= 1'b0;
        end else begin
            if (!exp_stall) begin
                m_dec <= '{inst_valid, cur_wen, inst[11:7], inst[19:15], inst[24:20]};
            end
            m_exe   <= m_dec;
            m_exe.v <= m_dec.v && !exp_stall;
            m_mem   <= m_exe.v;
            m_wb    <= m_mem;
        end
        take <= !rst && retire_valid;
    end

    // record checked at a rising edge leaves the queue at the next falling edge
    always @(negedge clk) begin
        if (take && exp_q.size() != 0) begin
            exp_q.delete(0);
            refresh_head();
        end
    end

    stall_check: assert property (@(posedge clk) disable iff (rst) stall == exp_stall)
        else report_mismatch("stall", 32'($sampled(exp_stall)), 32'($sampled(stall)));
    valid_check: assert property (@(posedge clk) disable iff (rst) retire_valid == m_wb)
        else report_mismatch("retire_valid", 32'($sampled(m_wb)),
                             32'($sampled(retire_valid)));
    order_check: assert property (@(posedge clk) disable iff (rst) retire_valid |-> head_ok)
        else report_error("retire seen with no instruction left to retire");
    pc_check: assert property (@(posedge clk) disable iff (rst)
            retire_valid && head_ok |-> retire.pc == head.rec.pc)
        else report_mismatch("retire.pc", $sampled(head.rec.pc), $sampled(retire.pc));
    rd_check: assert property (@(posedge clk) disable iff (rst)
            retire_valid && head_ok |-> retire.rd == head.rec.rd)
        else report_mismatch("retire.rd", 32'($sampled(head.rec.rd)),
                             32'($sampled(retire.rd)));
    wen_check: assert property (@(posedge clk) disable iff (rst)
            retire_valid && head_ok |-> retire.wen == head.rec.wen)
        else report_mismatch("retire.wen", 32'($sampled(head.rec.wen)),
                             32'($sampled(retire.wen)));
    data_check: assert property (@(posedge clk) disable iff (rst)
            retire_valid && head_ok && head.chk |-> retire.data == head.rec.data)
        else report_mismatch("retire.data", $sampled(head.rec.data), $sampled(retire.data));

    initial begin
        void'($urandom(32'hafeaf91d));
        errors     = 0;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = 32'd0;
        pc         = 32'd0;
        cur_wen    = 1'b0;
        take       = 1'b0;
        head       = '0;
        head_ok    = 1'b0;
        next_pc    = 32'h0000_1000;
        foreach (regs[i]) begin
            regs[i] = 32'd0;
        end
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        // random register contents, each addi waits on its lui
        for (int r = 1; r <= 8; r++) begin
            issue(K_LUI, 5'(r), 5'd0, 5'd0, $urandom());
            issue(8, 5'(r), 5'(r), 5'd0, $urandom());
        end
        for (int k = 0; k < K_NOP; k++) begin
            if (k != 9) begin
                issue(k, 5'(k + 12), 5'($urandom_range(1, 8)), 5'($urandom_range(1, 8)),
                      $urandom());
            end
        end
        issue(8, 5'd10, 5'd1, 5'd0, 32'd7);
        issue(0, 5'd11, 5'd10, 5'd2, 32'd0);
        // x12 written twice, then read from the mem slot and the wb slot
        issue(8, 5'd12, 5'd1, 5'd0, 32'd1);
        issue(8, 5'd12, 5'd2, 5'd0, 32'd2);
        issue(3, 5'd13, 5'd3, 5'd4, 32'd0);
        issue(1, 5'd14, 5'd12, 5'd5, 32'd0);
        issue(4, 5'd15, 5'd12, 5'd6, 32'd0);
        issue(8, 5'd0, 5'd1, 5'd0, 32'd5);
        issue(0, 5'd16, 5'd0, 5'd0, 32'd0);
        issue(0, 5'd17, 5'd0, 5'd1, 32'd0);
        issue(K_NOP, 5'd3, 5'd1, 5'd0, $urandom());
        issue(0, 5'd18, 5'd3, 5'd0, 32'd0);
        for (int n = 0; n < 20; n++) begin
            kind = int'($urandom_range(0, K_NOP));
            if (kind == 9) begin
                kind = 8;
            end
            issue(kind, 5'($urandom_range(0, 31)), 5'($urandom_range(0, 31)),
                  5'($urandom_range(0, 31)), $urandom());
        end
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: writeback_stage.sv
`default_nettype none

module writeback_stage (
    input  logic            clk,
    input  logic            rst,
    input  rv_pkg::res_t    exe_res,
    output logic [31:0]     regfile [32],
    output rv_pkg::fw_t     mem_fw,
    output rv_pkg::fw_t     wb_fw,
    output logic            retire_valid,
    output rv_pkg::retire_t retire
);
    import rv_pkg::*;

    res_t mem_q;
    res_t wb_q;
    logic wb_wen;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_q.valid <= 1'b0;
            wb_q.valid  <= 1'b0;
        end else begin
            mem_q <= exe_res;
            wb_q  <= mem_q;
        end
    end

    // x0 is never written
    assign wb_wen = wb_q.valid && wb_q.rf_wen && (wb_q.wb_addr != 5'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regfile[i] <= 32'd0;
            end
        end else if (wb_wen) begin
            regfile[wb_q.wb_addr] <= wb_q.data;
        end
    end

    always_comb begin
        mem_fw.valid = mem_q.valid && mem_q.rf_wen && (mem_q.wb_addr != 5'd0);
        mem_fw.addr  = mem_q.wb_addr;
        mem_fw.wdata = mem_q.data;
        wb_fw.valid  = wb_wen;
        wb_fw.addr   = wb_q.wb_addr;
        wb_fw.wdata  = wb_q.data;
    end

    // one retire report per instruction leaving the wb slot
    assign retire_valid = wb_q.valid;

    always_comb begin
        retire.pc   = wb_q.pc;
        retire.rd   = wb_q.wb_addr;
        retire.wen  = wb_wen;
        retire.data = wb_q.data;
    end

endmodule

`default_nettype wire
